// ==== soc_bus_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Strobe bus shared by the master and the memory map decode
// Word addressed bus with byte masks, no busy or wait states
//////////////////////////////////////////////////////////////////////

package soc_bus_pkg;

   // Bus widths
   localparam int WORD_W   = 32;
   localparam int MASK_W   = WORD_W / 8;   // One bit per byte lane
   localparam int REGION_W = 4;            // Top address nibble

   // RAM geometry
   localparam int RAM_WORDS = 1024;
   localparam int RAM_AW    = $clog2(RAM_WORDS);

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [MASK_W-1:0] wmask_t;

   // Request from the external master
   typedef struct packed {
      word_t  addr;    // Byte address, word aligned
      word_t  wdata;
      wmask_t wmask;   // Nonzero mask means write this cycle
      logic   rstrb;   // One cycle read request
   } bus_req_t;

   // Memory map, selected by addr[31:28]
   typedef enum logic [REGION_W-1:0] {
      REGION_RAM = 4'h0,   // 0x0000_0000
      REGION_IO  = 4'h4    // 0x4000_0000
   } region_e;

endpackage

// ==== soc_io_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// IO map with one-hot register select bits in the address
// Only one select bit should be set per access, reads OR them
//////////////////////////////////////////////////////////////////////

package soc_io_pkg;

   import soc_bus_pkg::*;

   // Write operation from addr[3:2]
   typedef enum logic [1:0] {
      IO_WRITE  = 2'd0,   // +0x0
      IO_CLEAR  = 2'd1,   // +0x4
      IO_SET    = 2'd2,   // +0x8
      IO_TOGGLE = 2'd3    // +0xC
   } io_op_e;

   // One-hot select bits, address bit numbers
   localparam int SEL_GPIO      = 4;    // Byte lanes: dir, out, in
   localparam int SEL_SCRATCH   = 5;    // Byte writable
   localparam int SEL_LEDS      = 8;    // Direct LED bits
   localparam int SEL_SDM_RED   = 9;
   localparam int SEL_SDM_GREEN = 10;
   localparam int SEL_SDM_BLUE  = 11;
   localparam int SEL_TICKS     = 18;   // Timer counter
   localparam int SEL_RELOAD    = 19;   // Timer reload value

   // Peripheral widths
   localparam int GPIO_W = 8;
   localparam int SDM_W  = 16;

   // Red sits in bit 0, as in the LED register
   typedef struct packed {
      logic blue;
      logic green;
      logic red;
   } rgb_t;

   // Brightness per channel
   typedef struct packed {
      logic [SDM_W-1:0] blue;
      logic [SDM_W-1:0] green;
      logic [SDM_W-1:0] red;
   } sdm_level_t;

   // Timer register writes, always plain data
   typedef struct packed {
      logic  ticks_we;
      logic  reload_we;
      word_t value;
   } timer_wr_t;

endpackage

// ==== bus_decoder.sv ====
//////////////////////////////////////////////////////////////////////
// Region decode and read return, data one cycle after the strobe
// Master must hold the address through the data cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module bus_decoder
   import soc_bus_pkg::*;
(
   input  logic     clk,
   input  bus_req_t bus_req,
   input  word_t    ram_rdata,   // Registered RAM word
   input  word_t    io_rdata,    // Buffered IO word
   output wmask_t   ram_wmask,
   output logic     io_wstrb,
   output logic     io_rstrb,
   output word_t    rdata
);

   region_e region;      // Region of the current request
   region_e rd_region;   // Region of the last read strobe
   logic    wr_any;

   assign region = region_e'(bus_req.addr[WORD_W-1 -: REGION_W]);
   assign wr_any = |bus_req.wmask;

   // Write mask only reaches RAM inside its region
   assign ram_wmask = (region == REGION_RAM) ? bus_req.wmask : '0;

   // IO strobes
   assign io_wstrb = wr_any && (region == REGION_IO);
   assign io_rstrb = bus_req.rstrb && (region == REGION_IO);

   // The address is held into the data cycle, so the region
   // captured at the strobe is still the one being addressed
   always_ff @(posedge clk)
   begin
      if (bus_req.rstrb)
      begin
         rd_region <= region;
      end
   end

   // Return path, unmapped regions read as zero
   always_comb
   begin
      case (rd_region)
         REGION_RAM: rdata = ram_rdata;
         REGION_IO:  rdata = io_rdata;
         default:    rdata = '0;
      endcase
   end

endmodule

// ==== word_ram.sv ====
//////////////////////////////////////////////////////////////////////
// Byte masked word RAM, read latency of one cycle
// Contents are undefined until written, WORDS a power of two
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module word_ram
   import soc_bus_pkg::*;
#(
   parameter int WORDS = RAM_WORDS
)
(
   input  logic              clk,
   input  logic [RAM_AW-1:0] addr,    // Word address
   input  wmask_t            wmask,   // Byte lane enables
   input  word_t             wdata,
   output word_t             rdata
);

   word_t mem [WORDS];

   // Byte lane writes
   always_ff @(posedge clk)
   begin
      for (int b = 0; b < MASK_W; b++)
      begin
         if (wmask[b])
         begin
            mem[addr][8*b +: 8] <= wdata[8*b +: 8];
         end
      end
   end

   // Read port runs every cycle, old data on a write
   always_ff @(posedge clk)
   begin
      rdata <= mem[addr];
   end

endmodule

// ==== io_regfile.sv ====
//////////////////////////////////////////////////////////////////////
// IO registers with one-hot select and clear/set/toggle writes
// Read data is buffered at the strobe, LEDs and brightness word only
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module io_regfile
   import soc_bus_pkg::*;
   import soc_io_pkg::*;
(
   input  logic              clk,
   input  logic              reset_button,
   input  bus_req_t          bus_req,
   input  logic              io_wstrb,
   input  logic              io_rstrb,
   input  logic [GPIO_W-1:0] gpio_in,
   input  word_t             ticks,       // Timer readback
   input  word_t             reload,
   output word_t             io_rdata,    // Valid in the cycle after the strobe
   output logic [GPIO_W-1:0] gpio_out,
   output logic [GPIO_W-1:0] gpio_dir,    // 1 drives the pin
   output rgb_t              leds,
   output sdm_level_t        sdm_level,
   output timer_wr_t         timer_wr
);

   localparam int GPIO_PAD = WORD_W - 3*GPIO_W;
   localparam int SDM_PAD  = WORD_W - SDM_W;
   localparam int LED_PAD  = WORD_W - $bits(rgb_t);

   word_t  rd_word;    // Combinational read word
   word_t  mod_word;   // Value after the write operation
   word_t  scratch;
   io_op_e op;
   logic   [WORD_W-1:0] sel;

   assign sel = bus_req.addr;
   assign op  = io_op_e'(bus_req.addr[3:2]);

   // OR of every selected register
   always_comb
   begin
      rd_word = '0;
      if (sel[SEL_GPIO])      rd_word |= {{GPIO_PAD{1'b0}}, gpio_dir, gpio_out, gpio_in};
      if (sel[SEL_SCRATCH])   rd_word |= scratch;
      if (sel[SEL_LEDS])      rd_word |= {{LED_PAD{1'b0}}, leds};
      if (sel[SEL_SDM_RED])   rd_word |= {{SDM_PAD{1'b0}}, sdm_level.red};
      if (sel[SEL_SDM_GREEN]) rd_word |= {{SDM_PAD{1'b0}}, sdm_level.green};
      if (sel[SEL_SDM_BLUE])  rd_word |= {{SDM_PAD{1'b0}}, sdm_level.blue};
      if (sel[SEL_TICKS])     rd_word |= ticks;
      if (sel[SEL_RELOAD])    rd_word |= reload;
   end

   // Atomic bit operations on the current value
   always_comb
   begin
      case (op)
         IO_CLEAR:  mod_word = rd_word & ~bus_req.wdata;
         IO_SET:    mod_word = rd_word | bus_req.wdata;
         IO_TOGGLE: mod_word = rd_word ^ bus_req.wdata;
         default:   mod_word = bus_req.wdata;   // Plain write
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset_button)
      begin
         gpio_out  <= '0;
         gpio_dir  <= '0;
         scratch   <= '0;
         leds      <= '0;
         sdm_level <= '0;
      end
      else
      begin
         // Byte lanes, GPIO input in lane 0 is read only
         if (io_wstrb && sel[SEL_GPIO] && bus_req.wmask[1]) gpio_out <= mod_word[15:8];
         if (io_wstrb && sel[SEL_GPIO] && bus_req.wmask[2]) gpio_dir <= mod_word[23:16];
         for (int b = 0; b < MASK_W; b++)
         begin
            if (io_wstrb && sel[SEL_SCRATCH] && bus_req.wmask[b])
            begin
               scratch[8*b +: 8] <= mod_word[8*b +: 8];
            end
         end

         // Word wide registers
         if (io_wstrb && sel[SEL_LEDS])      leds            <= rgb_t'(mod_word[2:0]);
         if (io_wstrb && sel[SEL_SDM_RED])   sdm_level.red   <= mod_word[SDM_W-1:0];
         if (io_wstrb && sel[SEL_SDM_GREEN]) sdm_level.green <= mod_word[SDM_W-1:0];
         if (io_wstrb && sel[SEL_SDM_BLUE])  sdm_level.blue  <= mod_word[SDM_W-1:0];
      end
   end

   // Timer takes plain data, counter keeps running otherwise
   assign timer_wr.ticks_we  = io_wstrb && sel[SEL_TICKS];
   assign timer_wr.reload_we = io_wstrb && sel[SEL_RELOAD];
   assign timer_wr.value     = bus_req.wdata;

   // Capture the strobe cycle values
   always_ff @(posedge clk)
   begin
      if (io_rstrb)
      begin
         io_rdata <= rd_word;
      end
   end

endmodule

// ==== interval_timer.sv ====
//////////////////////////////////////////////////////////////////////
// Free running tick counter, reloads after all ones
// irq is a single cycle pulse one edge after the overflow value
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module interval_timer
   import soc_bus_pkg::*;
   import soc_io_pkg::*;
(
   input  logic      clk,
   input  logic      reset_button,
   input  timer_wr_t timer_wr,
   output word_t     ticks,
   output word_t     reload,
   output logic      irq
);

   logic [WORD_W:0] ticks_inc;   // Carry out marks overflow
   word_t           ticks_next;

   assign ticks_inc  = {1'b0, ticks} + 1'b1;
   assign ticks_next = ticks_inc[WORD_W] ? reload : ticks_inc[WORD_W-1:0];

   always_ff @(posedge clk)
   begin
      if (reset_button)
      begin
         ticks  <= '0;
         reload <= '0;
         irq    <= 1'b0;
      end
      else
      begin
         if (timer_wr.ticks_we) ticks <= timer_wr.value;   // Bus write wins
         else                   ticks <= ticks_next;
         if (timer_wr.reload_we)
         begin
            reload <= timer_wr.value;
         end
         irq <= ticks_inc[WORD_W];   // High only for the wrap edge
      end
   end

endmodule

// ==== sdm_led.sv ====
//////////////////////////////////////////////////////////////////////
// First order sigma-delta brightness per colour
// Level B gives B high cycles in every 65536, direct bit forces high
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sdm_led
   import soc_io_pkg::*;
(
   input  logic       clk,
   input  logic       reset_button,
   input  sdm_level_t sdm_level,
   input  rgb_t       leds,   // Direct on bits
   output rgb_t       rgb
);

   localparam int CH = 3;

   logic [SDM_W-1:0] level [CH];
   logic [SDM_W-1:0] phase [CH];   // Phase accumulators
   logic [CH-1:0]    carry;        // Registered carry, the modulated bit

   // Channel order matches rgb_t, red first
   assign level[0] = sdm_level.red;
   assign level[1] = sdm_level.green;
   assign level[2] = sdm_level.blue;

   always_ff @(posedge clk)
   begin
      if (reset_button)
      begin
         carry <= '0;
         for (int i = 0; i < CH; i++) phase[i] <= '0;
      end
      else
      begin
         for (int i = 0; i < CH; i++)
         begin
            {carry[i], phase[i]} <= phase[i] + level[i];   // 17 bit sum
         end
      end
   end

   assign rgb.red   = carry[0] | leds.red;
   assign rgb.green = carry[1] | leds.green;
   assign rgb.blue  = carry[2] | leds.blue;

endmodule

// ==== soc_peripherals.sv ====
//////////////////////////////////////////////////////////////////////
// Peripheral side of the playground SoC, RAM at 0x0 and IO at 0x4
// Fixed latency strobe bus, reads return one cycle after the strobe
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module soc_peripherals
   import soc_bus_pkg::*;
   import soc_io_pkg::*;
(
   input  logic              clk,
   input  logic              reset_button,
   input  bus_req_t          bus_req,
   input  logic [GPIO_W-1:0] gpio_in,
   output word_t             rdata,
   output logic [GPIO_W-1:0] gpio_out,
   output logic [GPIO_W-1:0] gpio_dir,
   output rgb_t              rgb,
   output logic              irq
);

   wmask_t     ram_wmask;
   logic       io_wstrb;
   logic       io_rstrb;
   word_t      ram_rdata;
   word_t      io_rdata;
   timer_wr_t  timer_wr;
   word_t      ticks;
   word_t      reload;
   rgb_t       leds;
   sdm_level_t sdm_level;

   bus_decoder i_bus_decoder (
      .clk       (clk),
      .bus_req   (bus_req),
      .ram_rdata (ram_rdata),
      .io_rdata  (io_rdata),
      .ram_wmask (ram_wmask),
      .io_wstrb  (io_wstrb),
      .io_rstrb  (io_rstrb),
      .rdata     (rdata)
   );

   // Word address from byte address
   word_ram i_word_ram (
      .clk   (clk),
      .addr  (bus_req.addr[RAM_AW+1:2]),
      .wmask (ram_wmask),
      .wdata (bus_req.wdata),
      .rdata (ram_rdata)
   );

   io_regfile i_io_regfile (
      .clk          (clk),
      .reset_button (reset_button),
      .bus_req      (bus_req),
      .io_wstrb     (io_wstrb),
      .io_rstrb     (io_rstrb),
      .gpio_in      (gpio_in),
      .ticks        (ticks),
      .reload       (reload),
      .io_rdata     (io_rdata),
      .gpio_out     (gpio_out),
      .gpio_dir     (gpio_dir),
      .leds         (leds),
      .sdm_level    (sdm_level),
      .timer_wr     (timer_wr)
   );

   interval_timer i_interval_timer (
      .clk          (clk),
      .reset_button (reset_button),
      .timer_wr     (timer_wr),
      .ticks        (ticks),
      .reload       (reload),
      .irq          (irq)
   );

   sdm_led i_sdm_led (
      .clk          (clk),
      .reset_button (reset_button),
      .sdm_level    (sdm_level),
      .leds         (leds),
      .rgb          (rgb)
   );

endmodule

// ==== tb_soc_peripherals.sv ====
//////////////////////////////////////////////////////////////////////
// Self-checking testbench for the peripheral side of the SoC
// Reads compared against a byte-merged model, ticks not modelled
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_soc_peripherals
   import soc_bus_pkg::*;
   import soc_io_pkg::*;
;

   localparam int    PERIOD       = 100;
   localparam int    RESET_CYCLES = 10;
   localparam int    RAM_TESTS    = 200;
   localparam int    BAD_READS    = 10;
   localparam int    IO_TESTS     = 60;
   localparam int    TIMER_GAP    = 20;      // Ticks written as all ones minus this
   localparam int    SDM_CYCLES   = 65536;
   localparam word_t SEED         = 32'd84373;
   localparam word_t IO_BASE      = {REGION_IO, 28'h0};
   // Two cycles per bus access, one per end of test
   localparam int    TEST_CYCLES  = RESET_CYCLES + 2*6 + 2*(3*RAM_TESTS + BAD_READS)
                                    + 4*IO_TESTS + 4 + 4 + TIMER_GAP + 9 + SDM_CYCLES + 9;
   localparam longint WATCHDOG_NS = longint'(TEST_CYCLES) * 11 / 10 * PERIOD;

   logic              clk;
   logic              reset_button;
   bus_req_t          bus_req;
   logic [GPIO_W-1:0] gpio_in;
   word_t             rdata;
   logic [GPIO_W-1:0] gpio_out;
   logic [GPIO_W-1:0] gpio_dir;
   rgb_t              rgb;
   logic              irq;

   // Reference model state
   word_t             ram_model [RAM_WORDS];
   logic [GPIO_W-1:0] m_gpio_out;
   logic [GPIO_W-1:0] m_gpio_dir;
   word_t             m_scratch;
   rgb_t              m_leds;
   logic [SDM_W-1:0]  m_sdm [3];   // Red, green, blue
   word_t             m_reload;

   // Pending checks for the compare process
   word_t got_q [$];
   word_t exp_q [$];
   string what_q [$];
   event  check_ev;
   word_t cmp_got;
   word_t cmp_exp;
   string cmp_what;

   word_t lcg_state = SEED;
   int    checks = 0;
   int    errors = 0;
   int    test_num = 1;
   int    test_errors = 0;
   int    red_count;
   int    blue_count;
   int    sel_bit;
   word_t addr;
   word_t data;
   word_t level;
   word_t addr_list [RAM_TESTS];

   soc_peripherals i_soc_peripherals (
      .clk          (clk),
      .reset_button (reset_button),
      .bus_req      (bus_req),
      .gpio_in      (gpio_in),
      .rdata        (rdata),
      .gpio_out     (gpio_out),
      .gpio_dir     (gpio_dir),
      .rgb          (rgb),
      .irq          (irq)
   );

   always #(PERIOD/2) clk = ~clk;

   function automatic word_t lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state ^ (lcg_state >> 15);   // Fold high bits into the weak low ones
   endfunction

   // Expected read word for an address, from the model
   function automatic word_t expected(word_t a);
      word_t v;
      v = '0;
      if (a[31:28] == REGION_RAM)
      begin
         v = ram_model[a[RAM_AW+1:2]];
      end
      else if (a[31:28] == REGION_IO)
      begin
         if (a[SEL_GPIO])      v |= {8'h00, m_gpio_dir, m_gpio_out, gpio_in};
         if (a[SEL_SCRATCH])   v |= m_scratch;
         if (a[SEL_LEDS])      v |= {29'h0, m_leds};
         if (a[SEL_SDM_RED])   v |= {16'h0, m_sdm[0]};
         if (a[SEL_SDM_GREEN]) v |= {16'h0, m_sdm[1]};
         if (a[SEL_SDM_BLUE])  v |= {16'h0, m_sdm[2]};
         if (a[SEL_RELOAD])    v |= m_reload;
      end
      return v;   // Unmapped regions read zero
   endfunction

   // Apply one write to the model
   task automatic model_write(word_t a, word_t wd, wmask_t wm);
      word_t old;
      word_t mod;
      old = expected(a);
      case (a[3:2])
         2'd1:    mod = old & ~wd;   // Clear
         2'd2:    mod = old | wd;    // Set
         2'd3:    mod = old ^ wd;    // Toggle
         default: mod = wd;
      endcase
      for (int b = 0; b < MASK_W; b++)
      begin
         if (wm[b] && a[31:28] == REGION_RAM) ram_model[a[RAM_AW+1:2]][8*b +: 8] = wd[8*b +: 8];
         if (wm[b] && a[31:28] == REGION_IO && a[SEL_SCRATCH]) m_scratch[8*b +: 8] = mod[8*b +: 8];
      end
      if (a[31:28] == REGION_IO && wm != 0)
      begin
         if (a[SEL_GPIO] && wm[1]) m_gpio_out = mod[15:8];
         if (a[SEL_GPIO] && wm[2]) m_gpio_dir = mod[23:16];
         if (a[SEL_LEDS])          m_leds     = rgb_t'(mod[2:0]);   // Word wide
         if (a[SEL_SDM_RED])       m_sdm[0]   = mod[15:0];
         if (a[SEL_SDM_GREEN])     m_sdm[1]   = mod[15:0];
         if (a[SEL_SDM_BLUE])      m_sdm[2]   = mod[15:0];
         if (a[SEL_RELOAD])        m_reload   = wd;                  // Plain data only
      end
   endtask

   task automatic check(word_t got, word_t exp, string what);
      got_q.push_back(got);
      exp_q.push_back(exp);
      what_q.push_back(what);
      -> check_ev;
   endtask

   task automatic bus_write(word_t a, word_t wd, wmask_t wm);
      @(negedge clk);
      bus_req.addr  = a;
      bus_req.wdata = wd;
      bus_req.wmask = wm;
      model_write(a, wd, wm);
      @(negedge clk);   // Written at the edge in between
      bus_req.wmask = '0;
   endtask

   // Data is sampled in the middle of the cycle after the strobe
   task automatic bus_read(word_t a, string what);
      word_t exp;
      @(negedge clk);
      bus_req.addr  = a;
      bus_req.rstrb = 1'b1;
      exp = expected(a);
      @(negedge clk);
      bus_req.rstrb = 1'b0;   // Address stays held
      check(rdata, exp, what);
   endtask

   task automatic end_test(string name);
      @(negedge clk);   // Compare process drains meanwhile
      $display("Test %0d %s: %0d errors", test_num, name, errors - test_errors);
      test_num++;
      test_errors = errors;
   endtask

   // Compare process
   always @(check_ev)
   begin
      while (got_q.size() > 0)
      begin
         cmp_got  = got_q.pop_front();
         cmp_exp  = exp_q.pop_front();
         cmp_what = what_q.pop_front();
         checks++;
         assert (cmp_got === cmp_exp)
         else
         begin
            errors++;
            $display("FAILED at %0t ns: %s read %h expected %h", $time, cmp_what, cmp_got,
                     cmp_exp);
         end
      end
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   initial
   begin
      clk          = 1'b0;
      reset_button = 1'b1;
      bus_req      = '0;
      gpio_in      = '0;
      m_gpio_out   = '0;
      m_gpio_dir   = '0;
      m_scratch    = '0;
      m_leds       = '0;
      m_reload     = '0;
      for (int c = 0; c < 3; c++) m_sdm[c] = '0;
      repeat (RESET_CYCLES) @(negedge clk);
      reset_button = 1'b0;

      // Reset values
      check(irq, 0, "irq");
      check(gpio_out, 0, "gpio_out");
      check(gpio_dir, 0, "gpio_dir");
      check(rgb, 0, "rgb");
      bus_read(IO_BASE | (1 << SEL_LEDS), "leds");
      bus_read(IO_BASE | (1 << SEL_SDM_RED), "sdm red");
      bus_read(IO_BASE | (1 << SEL_SDM_GREEN), "sdm green");
      bus_read(IO_BASE | (1 << SEL_SDM_BLUE), "sdm blue");
      bus_read(IO_BASE | (1 << SEL_SCRATCH), "scratch");
      bus_read(IO_BASE | (1 << SEL_RELOAD), "reload");
      end_test("reset values");

      // Full word first so that no lane stays undefined
      for (int i = 0; i < RAM_TESTS; i++)
      begin
         addr_list[i] = (lcg_next() % RAM_WORDS) << 2;
         bus_write(addr_list[i], lcg_next(), 4'hF);
         bus_write(addr_list[i], lcg_next(), wmask_t'(lcg_next()));
      end
      for (int i = 0; i < RAM_TESTS; i++)
      begin
         bus_read(addr_list[i], $sformatf("ram at %h", addr_list[i]));
      end
      for (int i = 0; i < BAD_READS; i++)
      begin
         data = lcg_next();
         addr = {data[31:28], data[27:2], 2'b00};
         if (addr[31:28] == 4'h0 || addr[31:28] == 4'h4) addr[31:28] += 4'h1;
         bus_read(addr, $sformatf("unmapped %h", addr));
      end
      end_test("ram and unmapped regions");

      @(negedge clk);
      for (int i = 0; i < IO_TESTS; i++)
      begin
         gpio_in = GPIO_W'(lcg_next());   // New pin value each round
         case (lcg_next() % 3)
            0:       sel_bit = SEL_GPIO;
            1:       sel_bit = SEL_SCRATCH;
            default: sel_bit = SEL_LEDS;
         endcase
         addr = IO_BASE | (word_t'(1) << sel_bit) | ((lcg_next() % 4) << 2);
         bus_write(addr, lcg_next(), wmask_t'(lcg_next() % 15 + 1));
         bus_read(addr, $sformatf("io %h", addr));
         check(gpio_out, m_gpio_out, "gpio_out pins");
         check(gpio_dir, m_gpio_dir, "gpio_dir pins");
         check(rgb, m_leds, "rgb with zero brightness");
      end
      end_test("io operations");

      level = lcg_next() & 32'h0FFF_FFFF;   // Far from a second wrap
      bus_write(IO_BASE | (1 << SEL_RELOAD), level, 4'hF);
      bus_write(IO_BASE | (1 << SEL_TICKS), 32'hFFFF_FFFF - TIMER_GAP, 4'hF);
      // Now just after the ticks write edge
      for (int k = 0; k <= TIMER_GAP + 4; k++)
      begin
         check(irq, (k == TIMER_GAP + 1), $sformatf("irq after write edge +%0d", k));
         @(negedge clk);
      end
      bus_read(IO_BASE | (1 << SEL_RELOAD), "reload after wrap");
      end_test("interval timer");

      level = lcg_next() % 65536;
      bus_write(IO_BASE | (1 << SEL_LEDS), 32'h4, 4'hF);   // Blue direct bit only
      bus_write(IO_BASE | (1 << SEL_SDM_RED), level, 4'hF);
      red_count  = 0;
      blue_count = 0;
      repeat (SDM_CYCLES)
      begin
         @(negedge clk);
         red_count  += rgb.red;
         blue_count += rgb.blue;
      end
      check(red_count, level, "red high cycles");
      check(blue_count, SDM_CYCLES, "blue high cycles");
      end_test("sigma-delta brightness");

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
      begin
         $display("TEST RESULT: PASS");
      end
      else
      begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== all.f ====
soc_bus_pkg.sv
soc_io_pkg.sv
bus_decoder.sv
word_ram.sv
io_regfile.sv
interval_timer.sv
sdm_led.sv
soc_peripherals.sv
tb_soc_peripherals.sv

// ==== Bender.yml ====
package:
  name: soc_peripherals

sources:
  - soc_bus_pkg.sv
  - soc_io_pkg.sv
  - bus_decoder.sv
  - word_ram.sv
  - io_regfile.sv
  - interval_timer.sv
  - sdm_led.sv
  - soc_peripherals.sv
  - target: simulation
    files:
      - tb_soc_peripherals.sv
